//--- sources.f
stitch_pkg.sv
cam_capture.sv
tile_buffer.sv
video_timing.sv
quad_reader.sv
stitch_top.sv
tb_clock_gen.sv
tb_stitch_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_stitch_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_stitch_top.sv
module tb_stitch_top
    import stitch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TILE_H   = 8;
    localparam int TILE_V   = 4;
    localparam int H_SYNC   = 2;
    localparam int H_BACK   = 3;
    localparam int H_FRONT  = 2;
    localparam int V_SYNC   = 1;
    localparam int V_BACK   = 4;
    localparam int V_FRONT  = 1;
    localparam int H_TOTAL  = H_SYNC + H_BACK + 2 * TILE_H + H_FRONT;
    localparam int V_TOTAL  = V_SYNC + V_BACK + 2 * TILE_V + V_FRONT;
    localparam int TILE_PIX = TILE_H * TILE_V;
    localparam int RESET_CYCLES   = 16;
    localparam int CYCLE_LIMIT    = 2 * (5 * H_TOTAL * V_TOTAL + RESET_CYCLES);
    localparam int PIX_CHECKS_EXP = 3 * 4 * TILE_PIX;  // three displayed frames with data
    localparam logic [31:0] SEED  = 32'd15361;

    logic               hdmi_tx_pix_clk;
    logic               reset;
    logic               cam_vsync;
    logic               cam_href;
    logic [CAM_W/2-1:0] cam_data;
    logic               hdmi_rx_vs;
    logic               hdmi_rx_de;
    logic [PIX_W-1:0]   hdmi_rx_data;
    logic               hdmi_tx_vs;
    logic               hdmi_tx_hs;
    logic               hdmi_tx_de;
    logic [PIX_W-1:0]   hdmi_tx_data;

    logic [CAM_W-1:0] cam_words [TILE_PIX];   // last camera frame as rgb565
    logic [PIX_W-1:0] hdmi_words [TILE_PIX];  // last hdmi frame
    logic [31:0]      cam_rng;
    logic [31:0]      hdmi_rng;
    logic             model_valid = 1'b0;
    int errors       = 0;
    int checks       = 0;
    int pix_checks   = 0;
    int total_cycles = 0;
    int reset_cycles = 0;
    int cyc;                   // cycles since reset release
    int last_hs_rise;
    int last_vs_rise;
    int hs_len;
    int vs_len;
    int de_run;                // x within the active line
    int de_lines;              // y within the frame
    logic prev_hs;
    logic prev_vs;
    logic prev_de;

    tb_clock_gen #(.PERIOD(8.0), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .reset           (reset)
    );

    stitch_top #(
        .TILE_H  (TILE_H),
        .TILE_V  (TILE_V),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .H_FRONT (H_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .V_FRONT (V_FRONT)
    ) i_dut (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .reset           (reset),
        .cam_vsync       (cam_vsync),
        .cam_href        (cam_href),
        .cam_data        (cam_data),
        .hdmi_rx_vs      (hdmi_rx_vs),
        .hdmi_rx_de      (hdmi_rx_de),
        .hdmi_rx_data    (hdmi_rx_data),
        .hdmi_tx_vs      (hdmi_tx_vs),
        .hdmi_tx_hs      (hdmi_tx_hs),
        .hdmi_tx_de      (hdmi_tx_de),
        .hdmi_tx_data    (hdmi_tx_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // widen 565 fields by repeating their msbs at the bottom
    function automatic logic [PIX_W-1:0] rgb565_to_888(input logic [CAM_W-1:0] w);
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        r8 = (8'(w[15:11]) << 3) | (8'(w[15:11]) >> 2);
        g8 = (8'(w[10:5]) << 2) | (8'(w[10:5]) >> 4);
        b8 = (8'(w[4:0]) << 3) | (8'(w[4:0]) >> 2);
        return {r8, g8, b8};
    endfunction

    // top half shows the camera, bottom half the hdmi input, each tile twice
    function automatic logic [PIX_W-1:0] expected_pixel(input int px, input int py);
        int idx;
        idx = (py % TILE_V) * TILE_H + (px % TILE_H);
        if (py < TILE_V)
            return rgb565_to_888(cam_words[idx]);
        else
            return hdmi_words[idx];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idle(input string when);
        check_value(hdmi_tx_hs, 0, {"hs ", when});
        check_value(hdmi_tx_vs, 0, {"vs ", when});
        check_value(hdmi_tx_de, 0, {"de ", when});
        check_value(hdmi_tx_data, 0, {"data ", when});
    endtask

    task automatic wait_frame_start();
        @(posedge hdmi_tx_vs);
        @(negedge hdmi_tx_pix_clk);
    endtask

    // one tile row per href pulse, high byte first
    task automatic send_cam_frame();
        logic [CAM_W-1:0] w;
        cam_vsync = 1'b1;
        repeat (2) @(negedge hdmi_tx_pix_clk);
        cam_vsync = 1'b0;
        @(negedge hdmi_tx_pix_clk);
        for (int r = 0; r < TILE_V; r++)
        begin
            cam_href = 1'b1;
            for (int c = 0; c < TILE_H; c++)
            begin
                cam_rng = xorshift32(cam_rng);
                w = cam_rng[CAM_W-1:0];
                cam_words[r * TILE_H + c] = w;
                cam_data = w[15:8];
                @(negedge hdmi_tx_pix_clk);
                cam_data = w[7:0];
                @(negedge hdmi_tx_pix_clk);
            end
            cam_href = 1'b0;  // byte phase restarts here
            repeat (2) @(negedge hdmi_tx_pix_clk);
        end
    endtask

    task automatic send_hdmi_frame(input int extra);
        hdmi_rx_vs = 1'b1;
        repeat (2) @(negedge hdmi_tx_pix_clk);
        hdmi_rx_vs = 1'b0;
        @(negedge hdmi_tx_pix_clk);
        for (int i = 0; i < TILE_PIX + extra; i++)
        begin
            hdmi_rng = xorshift32(hdmi_rng);
            hdmi_rx_de   = 1'b1;
            hdmi_rx_data = hdmi_rng[PIX_W-1:0];
            if (i < TILE_PIX)
                hdmi_words[i] = hdmi_rng[PIX_W-1:0];  // overflow pixels are not kept
            @(negedge hdmi_tx_pix_clk);
        end
        hdmi_rx_de = 1'b0;
    endtask

    task automatic finish_run();
        check_value(pix_checks, PIX_CHECKS_EXP, "number of pixel checks");
        $display("checks %0d, pixel checks %0d, errors %0d", checks, pix_checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    endtask

    initial
    begin
        cam_vsync    = 1'b0;
        cam_href     = 1'b0;
        cam_data     = '0;
        hdmi_rx_vs   = 1'b0;
        hdmi_rx_de   = 1'b0;
        hdmi_rx_data = '0;
        cam_rng      = SEED;
        hdmi_rng     = xorshift32(SEED ^ 32'hffff_0000);  // separate stream per source
        @(negedge reset);
        wait_frame_start();
        fork
            send_cam_frame();
            send_hdmi_frame(4);
        join
        model_valid = 1'b1;
        wait_frame_start();  // same contents shown again
        wait_frame_start();
        fork
            send_cam_frame();
            send_hdmi_frame(4);
        join
        wait_frame_start();  // replaced contents shown in the frame before this
        repeat (4) @(negedge hdmi_tx_pix_clk);
        finish_run();
    end

    always @(posedge hdmi_tx_pix_clk)
    begin
        if (reset)
        begin
            reset_cycles++;
            if (reset_cycles > 1)
                check_idle("during reset");
            cyc          = 0;
            last_hs_rise = -1;
            last_vs_rise = -1;
            hs_len       = 0;
            vs_len       = 0;
            de_run       = 0;
            de_lines     = 0;
            prev_hs      = 1'b0;
            prev_vs      = 1'b0;
            prev_de      = 1'b0;
        end
        else
        begin
            cyc++;
            if (cyc == 2)  // outputs of the first edge out of reset
                check_idle("after reset");
            if (hdmi_tx_hs && !prev_hs)
            begin
                if (last_hs_rise >= 0)
                    check_value(cyc - last_hs_rise, H_TOTAL, "hs period");
                last_hs_rise = cyc;
            end
            if (hdmi_tx_hs)
                hs_len++;
            else if (prev_hs)
            begin
                check_value(hs_len, H_SYNC, "hs width");
                hs_len = 0;
            end
            if (hdmi_tx_vs && !prev_vs)
            begin
                if (last_vs_rise >= 0)
                begin
                    check_value(cyc - last_vs_rise, V_TOTAL * H_TOTAL, "vs period");
                    check_value(de_lines, 2 * TILE_V, "active lines per frame");
                end
                last_vs_rise = cyc;
                de_lines     = 0;
            end
            if (hdmi_tx_vs)
                vs_len++;
            else if (prev_vs)
            begin
                check_value(vs_len, V_SYNC * H_TOTAL, "vs width");
                vs_len = 0;
            end
            if (hdmi_tx_de)
            begin
                if (!prev_de)
                begin
                    check_value(cyc - last_hs_rise, H_SYNC + H_BACK, "de start after hs");
                    de_run = 0;
                end
                if (model_valid)
                begin
                    pix_checks++;
                    check_value(hdmi_tx_data, expected_pixel(de_run, de_lines),
                                $sformatf("pixel x=%0d y=%0d", de_run, de_lines));
                end
                de_run++;
            end
            else
            begin
                check_value(hdmi_tx_data, 0, "data while de low");
                if (prev_de)
                begin
                    check_value(de_run, 2 * TILE_H, "de cycles per line");
                    de_lines++;
                end
            end
            prev_hs = hdmi_tx_hs;
            prev_vs = hdmi_tx_vs;
            prev_de = hdmi_tx_de;
        end
    end

    always @(posedge hdmi_tx_pix_clk)
    begin
        total_cycles++;
        if (total_cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks %0d, pixel checks %0d, errors %0d", checks, pix_checks, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 16
)(
    output logic hdmi_tx_pix_clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        hdmi_tx_pix_clk = 1'b0;
        forever
            #(PERIOD / 2.0) hdmi_tx_pix_clk = ~hdmi_tx_pix_clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge hdmi_tx_pix_clk);
        @(negedge hdmi_tx_pix_clk);
        reset = 1'b0;  // release away from the active edge
    end

endmodule

//--- stitch_top.sv
module stitch_top
    import stitch_pkg::*;
#(
    parameter int TILE_H  = 8,
    parameter int TILE_V  = 4,
    parameter int H_SYNC  = 2,
    parameter int H_BACK  = 3,
    parameter int H_FRONT = 2,
    parameter int V_SYNC  = 1,
    parameter int V_BACK  = 4,
    parameter int V_FRONT = 1
)(
    input  logic               hdmi_tx_pix_clk,
    input  logic               reset,
    input  logic               cam_vsync,
    input  logic               cam_href,
    input  logic [CAM_W/2-1:0] cam_data,
    input  logic               hdmi_rx_vs,
    input  logic               hdmi_rx_de,
    input  logic [PIX_W-1:0]   hdmi_rx_data,
    output logic               hdmi_tx_vs,
    output logic               hdmi_tx_hs,
    output logic               hdmi_tx_de,
    output logic [PIX_W-1:0]   hdmi_tx_data
);

    localparam int AW = $clog2(TILE_H * TILE_V);
    localparam int XW = $clog2(2 * TILE_H);
    localparam int YW = $clog2(2 * TILE_V);

    logic             cam_we;
    logic [PIX_W-1:0] cam_pix;
    logic [AW-1:0]    rd_addr;      // shared by both buffers
    logic [PIX_W-1:0] cam_rd_pix;
    logic [PIX_W-1:0] hdmi_rd_pix;
    logic             hs;
    logic             vs;
    logic             de;
    logic [XW-1:0]    x;
    logic [YW-1:0]    y;

    cam_capture i_cam_capture (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .reset           (reset),
        .cam_href        (cam_href),
        .cam_data        (cam_data),
        .cam_we          (cam_we),
        .cam_pix         (cam_pix)
    );

    tile_buffer #(.TILE_H(TILE_H), .TILE_V(TILE_V)) i_cam_buf (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .reset           (reset),
        .frame_sync      (cam_vsync),
        .we              (cam_we),
        .wr_pix          (cam_pix),
        .rd_addr         (rd_addr),
        .rd_pix          (cam_rd_pix)
    );

    tile_buffer #(.TILE_H(TILE_H), .TILE_V(TILE_V)) i_hdmi_buf (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .reset           (reset),
        .frame_sync      (hdmi_rx_vs),
        .we              (hdmi_rx_de),  // one pixel per de cycle
        .wr_pix          (hdmi_rx_data),
        .rd_addr         (rd_addr),
        .rd_pix          (hdmi_rd_pix)
    );

    video_timing #(
        .TILE_H  (TILE_H),
        .TILE_V  (TILE_V),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .H_FRONT (H_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .V_FRONT (V_FRONT)
    ) i_video_timing (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .reset           (reset),
        .hs              (hs),
        .vs              (vs),
        .de              (de),
        .x               (x),
        .y               (y)
    );

    quad_reader #(.TILE_H(TILE_H), .TILE_V(TILE_V)) i_quad_reader (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .reset           (reset),
        .hs              (hs),
        .vs              (vs),
        .de              (de),
        .x               (x),
        .y               (y),
        .cam_rd_pix      (cam_rd_pix),
        .hdmi_rd_pix     (hdmi_rd_pix),
        .rd_addr         (rd_addr),
        .hdmi_tx_hs      (hdmi_tx_hs),
        .hdmi_tx_vs      (hdmi_tx_vs),
        .hdmi_tx_de      (hdmi_tx_de),
        .hdmi_tx_data    (hdmi_tx_data)
    );

endmodule

//--- quad_reader.sv
module quad_reader
    import stitch_pkg::*;
#(
    parameter int TILE_H = 8,
    parameter int TILE_V = 4
)(
    input  logic                               hdmi_tx_pix_clk,
    input  logic                               reset,
    input  logic                               hs,
    input  logic                               vs,
    input  logic                               de,
    input  logic [$clog2(2*TILE_H)-1:0]        x,
    input  logic [$clog2(2*TILE_V)-1:0]        y,
    input  logic [PIX_W-1:0]                   cam_rd_pix,
    input  logic [PIX_W-1:0]                   hdmi_rd_pix,
    output logic [$clog2(TILE_H*TILE_V)-1:0]   rd_addr,
    output logic                               hdmi_tx_hs,
    output logic                               hdmi_tx_vs,
    output logic                               hdmi_tx_de,
    output logic [PIX_W-1:0]                   hdmi_tx_data
);

    localparam int XW = $clog2(2 * TILE_H);
    localparam int YW = $clog2(2 * TILE_V);
    localparam int AW = $clog2(TILE_H * TILE_V);

    logic          left;
    logic          top;
    logic [XW-1:0] col;
    logic [YW-1:0] row;
    quad_t         quad;
    quad_t         quad_d1;  // aligned with rd_pix of the buffers
    logic          hs_d1;
    logic          vs_d1;
    logic          de_d1;
    logic [PIX_W-1:0] sel_pix;

    assign left = (x < XW'(TILE_H));
    assign top  = (y < YW'(TILE_V));
    assign col  = left ? x : x - XW'(TILE_H);  // x mod TILE_H
    assign row  = top ? y : y - YW'(TILE_V);

    assign rd_addr = AW'(row) * AW'(TILE_H) + AW'(col);  // same address for both tiles

    always_comb
    begin
        if (top)
            quad = left ? Q_CAM_L : Q_CAM_R;
        else
            quad = left ? Q_HDMI_L : Q_HDMI_R;
    end

    always_comb
    begin
        case (quad_d1)
            Q_CAM_L, Q_CAM_R: sel_pix = cam_rd_pix;
            default:          sel_pix = hdmi_rd_pix;
        endcase
    end

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (reset)
        begin
            quad_d1      <= Q_CAM_L;
            hs_d1        <= 1'b0;
            vs_d1        <= 1'b0;
            de_d1        <= 1'b0;
            hdmi_tx_hs   <= 1'b0;
            hdmi_tx_vs   <= 1'b0;
            hdmi_tx_de   <= 1'b0;
            hdmi_tx_data <= '0;
        end
        else
        begin
            quad_d1      <= quad;  // stage 1 while the buffers read
            hs_d1        <= hs;
            vs_d1        <= vs;
            de_d1        <= de;
            hdmi_tx_hs   <= hs_d1;  // stage 2 output register
            hdmi_tx_vs   <= vs_d1;
            hdmi_tx_de   <= de_d1;
            hdmi_tx_data <= de_d1 ? sel_pix : '0;  // black in blanking
        end
    end

endmodule

//--- video_timing.sv
module video_timing
    import stitch_pkg::*;
#(
    parameter int TILE_H  = 8,
    parameter int TILE_V  = 4,
    parameter int H_SYNC  = 2,
    parameter int H_BACK  = 3,
    parameter int H_FRONT = 2,
    parameter int V_SYNC  = 1,
    parameter int V_BACK  = 4,
    parameter int V_FRONT = 1
)(
    input  logic                          hdmi_tx_pix_clk,
    input  logic                          reset,
    output logic                          hs,
    output logic                          vs,
    output logic                          de,
    output logic [$clog2(2*TILE_H)-1:0]   x,
    output logic [$clog2(2*TILE_V)-1:0]   y
);

    localparam int H_DISP  = 2 * TILE_H;  // two tiles across
    localparam int V_DISP  = 2 * TILE_V;  // two tiles down
    localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);
    localparam int XW      = $clog2(H_DISP);
    localparam int YW      = $clog2(V_DISP);

    logic [HW-1:0]  h_cnt;
    logic [VW-1:0]  v_cnt;
    logic [HW-1:0]  h_off;  // h_cnt relative to first active pixel
    logic [VW-1:0]  v_off;
    logic           line_end;
    raster_phase_t  h_ph;
    raster_phase_t  v_ph;

    // sync starts at count zero, then back porch, active and front porch
    function automatic raster_phase_t phase_of(input int cnt, input int sync_len,
                                               input int back_len, input int disp_len);
        if (cnt < sync_len)
            return PH_SYNC;
        else if (cnt < sync_len + back_len)
            return PH_BACK;
        else if (cnt < sync_len + back_len + disp_len)
            return PH_ACTIVE;
        else
            return PH_FRONT;
    endfunction

    assign line_end = (h_cnt == HW'(H_TOTAL - 1));

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (reset)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (line_end)
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;  // next line
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    assign h_ph = phase_of(int'(h_cnt), H_SYNC, H_BACK, H_DISP);
    assign v_ph = phase_of(int'(v_cnt), V_SYNC, V_BACK, V_DISP);

    assign hs = (h_ph == PH_SYNC);
    assign vs = (v_ph == PH_SYNC);
    assign de = (h_ph == PH_ACTIVE) && (v_ph == PH_ACTIVE);

    assign h_off = h_cnt - HW'(H_SYNC + H_BACK);
    assign v_off = v_cnt - VW'(V_SYNC + V_BACK);
    assign x     = de ? h_off[XW-1:0] : '0;  // zero in blanking
    assign y     = de ? v_off[YW-1:0] : '0;

endmodule

//--- tile_buffer.sv
module tile_buffer
    import stitch_pkg::*;
#(
    parameter int TILE_H = 8,
    parameter int TILE_V = 4
)(
    input  logic                               hdmi_tx_pix_clk,
    input  logic                               reset,
    input  logic                               frame_sync,
    input  logic                               we,
    input  logic [PIX_W-1:0]                   wr_pix,
    input  logic [$clog2(TILE_H*TILE_V)-1:0]   rd_addr,
    output logic [PIX_W-1:0]                   rd_pix
);

    localparam int DEPTH = TILE_H * TILE_V;
    localparam int AW    = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);  // room for the full count

    logic [PIX_W-1:0] mem [DEPTH];
    logic             sync_d;     // frame_sync one cycle ago
    logic             sync_rise;
    logic [CNT_W-1:0] wr_cnt;     // next free word, stops at DEPTH
    logic             full;

    assign sync_rise = frame_sync && !sync_d;
    assign full      = (wr_cnt == CNT_W'(DEPTH));

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (reset)
        begin
            sync_d <= 1'b0;
            wr_cnt <= '0;
        end
        else
        begin
            sync_d <= frame_sync;
            if (sync_rise)
                wr_cnt <= '0;  // new frame starts at word zero
            else if (we && !full)
                wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // extra pixels past the tile are dropped until the next sync edge
    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (we && !full && !sync_rise)
            mem[wr_cnt[AW-1:0]] <= wr_pix;
        rd_pix <= mem[rd_addr];  // one cycle read
    end

endmodule

//--- cam_capture.sv
module cam_capture
    import stitch_pkg::*;
(
    input  logic               hdmi_tx_pix_clk,
    input  logic               reset,
    input  logic               cam_href,
    input  logic [CAM_W/2-1:0] cam_data,
    output logic               cam_we,
    output logic [PIX_W-1:0]   cam_pix
);

    logic [CAM_W/2-1:0] hi_byte;   // first byte of the pair
    logic               lo_phase;  // next byte completes a word
    logic [CAM_W-1:0]   word;      // rgb565 word being completed
    logic [CH_W-1:0]    r8;
    logic [CH_W-1:0]    g8;
    logic [CH_W-1:0]    b8;

    assign word = {hi_byte, cam_data};

    // widen each field by repeating its msbs
    assign r8 = {word[15:11], word[15:13]};
    assign g8 = {word[10:5], word[10:9]};
    assign b8 = {word[4:0], word[4:2]};

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (reset)
        begin
            lo_phase <= 1'b0;
            cam_we   <= 1'b0;
        end
        else
        begin
            cam_we   <= cam_href && lo_phase;  // one pulse per byte pair
            lo_phase <= cam_href ? ~lo_phase : 1'b0;  // realign on every line
        end
    end

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (cam_href && !lo_phase)
            hi_byte <= cam_data;  // high byte arrives first
        if (cam_href && lo_phase)
            cam_pix <= {r8, g8, b8};
    end

endmodule

//--- stitch_pkg.sv
package stitch_pkg;

    // pixel and word widths
    localparam int PIX_W = 24;  // rgb888 display pixel
    localparam int CAM_W = 16;  // rgb565 camera word
    localparam int CH_W  = 8;   // one colour channel of rgb888

    // position of a counter within a line or a frame
    typedef enum logic [1:0]
    {
        PH_SYNC   = 2'd0,  // sync pulse
        PH_BACK   = 2'd1,  // back porch
        PH_ACTIVE = 2'd2,  // visible area
        PH_FRONT  = 2'd3   // front porch
    } raster_phase_t;

    // mosaic quadrant of the output frame
    // the top row shows the camera and the bottom row the hdmi input,
    // each source twice side by side
    typedef enum logic [1:0]
    {
        Q_CAM_L  = 2'd0,  // top left
        Q_CAM_R  = 2'd1,  // top right
        Q_HDMI_L = 2'd2,  // bottom left
        Q_HDMI_R = 2'd3   // bottom right
    } quad_t;

endpackage
